//--- design/id_pkg.sv
package id_pkg;

    localparam int REG_AW  = 5;
    localparam int REG_NUM = 32;

    // top opcode, inst[31:26]
    localparam logic [5:0] OP_ARITH = 6'h00;
    localparam logic [5:0] OP_LU12I = 6'h05;
    localparam logic [5:0] OP_MEM   = 6'h0a;
    localparam logic [5:0] OP_JIRL  = 6'h13;
    localparam logic [5:0] OP_B     = 6'h14;
    localparam logic [5:0] OP_BL    = 6'h15;
    localparam logic [5:0] OP_BEQ   = 6'h16;
    localparam logic [5:0] OP_BNE   = 6'h17;
    localparam logic [5:0] OP_BLT   = 6'h18;
    localparam logic [5:0] OP_BLTU  = 6'h1a;

    // inst[25:22] under OP_ARITH and OP_MEM
    localparam logic [3:0] OP_ALU3R = 4'h0;
    localparam logic [3:0] OP_ADDI  = 4'ha;
    localparam logic [3:0] OP_ANDI  = 4'hd;
    localparam logic [3:0] OP_ORI   = 4'he;
    localparam logic [3:0] OP_LD_W  = 4'h2;
    localparam logic [3:0] OP_ST_W  = 4'h6;

    // inst[21:20] for three-register ops
    localparam logic [1:0] OP_LO_ALU3R = 2'h1;

    // inst[19:15]
    localparam logic [4:0] FUNC_ADD  = 5'h00;
    localparam logic [4:0] FUNC_SUB  = 5'h02;
    localparam logic [4:0] FUNC_SLT  = 5'h04;
    localparam logic [4:0] FUNC_SLTU = 5'h05;
    localparam logic [4:0] FUNC_NOR  = 5'h08;
    localparam logic [4:0] FUNC_AND  = 5'h09;
    localparam logic [4:0] FUNC_OR   = 5'h0a;
    localparam logic [4:0] FUNC_XOR  = 5'h0b;

    // one-hot alu op
    localparam int ALU_OP_W = 9;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_LUI  = 8;

    typedef union packed {
        struct packed {
            logic [5:0] op_hi;
            logic [3:0] op_mid;
            logic [1:0] op_lo;
            logic [4:0] op_func;
            logic [4:0] rk;
            logic [4:0] rj;
            logic [4:0] rd;
        } reg3;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] payload;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } imm;
    } inst_t;

endpackage

//--- design/ds_control.sv
`timescale 1ns/100ps

module ds_control (
    input  logic clk,
    input  logic reset,
    input  logic fs_to_ds_valid,
    input  logic es_allowin,
    input  logic load_use,
    output logic ds_valid,
    output logic ds_allowin,
    output logic ds_to_es_valid
);

    logic ready_go;

    // hold one cycle per load-use conflict
    assign ready_go       = ~load_use;
    assign ds_allowin     = ~ds_valid | (ready_go & es_allowin);
    assign ds_to_es_valid = ds_valid & ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    a_valid_out: assert property (
        @(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_valid
    );

    // a held instruction must still be there next cycle
    a_hold: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid && (load_use || !es_allowin) |-> !ds_allowin ##1 ds_valid
    );

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  id_pkg::inst_t                inst,
    output logic [id_pkg::ALU_OP_W-1:0]  alu_op,
    output logic                         src1_is_pc,
    output logic                         src2_is_imm,
    output logic                         src2_is_4,
    output logic                         mem_en,
    output logic                         mem_we,
    output logic [id_pkg::REG_AW-1:0]    dest,
    output logic                         gr_we,
    output logic                         res_from_mem,
    output logic [31:0]                  imm,
    output logic [id_pkg::REG_AW-1:0]    raddr1,
    output logic [id_pkg::REG_AW-1:0]    raddr2,
    output logic                         reads1,
    output logic                         reads2,
    output logic                         is_jirl,
    output logic                         is_b,
    output logic                         is_bl,
    output logic                         is_beq,
    output logic                         is_bne,
    output logic                         is_blt,
    output logic                         is_bltu
);

    logic alu3r, arith;
    logic is_add, is_sub, is_slt, is_sltu, is_and, is_or, is_xor, is_nor;
    logic is_addi, is_andi, is_ori, is_lu12i, is_ld, is_st;
    logic any_alu3r, cond_br;
    logic need_ui12, need_si12, need_si20, need_offs16, need_offs26;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    assign arith = inst.reg3.op_hi == id_pkg::OP_ARITH;
    assign alu3r = arith && inst.reg3.op_mid == id_pkg::OP_ALU3R
                   && inst.reg3.op_lo == id_pkg::OP_LO_ALU3R;

    assign is_add  = alu3r && inst.reg3.op_func == id_pkg::FUNC_ADD;
    assign is_sub  = alu3r && inst.reg3.op_func == id_pkg::FUNC_SUB;
    assign is_slt  = alu3r && inst.reg3.op_func == id_pkg::FUNC_SLT;
    assign is_sltu = alu3r && inst.reg3.op_func == id_pkg::FUNC_SLTU;
    assign is_nor  = alu3r && inst.reg3.op_func == id_pkg::FUNC_NOR;
    assign is_and  = alu3r && inst.reg3.op_func == id_pkg::FUNC_AND;
    assign is_or   = alu3r && inst.reg3.op_func == id_pkg::FUNC_OR;
    assign is_xor  = alu3r && inst.reg3.op_func == id_pkg::FUNC_XOR;

    assign is_addi = arith && inst.reg3.op_mid == id_pkg::OP_ADDI;
    assign is_andi = arith && inst.reg3.op_mid == id_pkg::OP_ANDI;
    assign is_ori  = arith && inst.reg3.op_mid == id_pkg::OP_ORI;
    assign is_ld   = inst.reg3.op_hi == id_pkg::OP_MEM && inst.reg3.op_mid == id_pkg::OP_LD_W;
    assign is_st   = inst.reg3.op_hi == id_pkg::OP_MEM && inst.reg3.op_mid == id_pkg::OP_ST_W;

    // lu12i.w has a 7-bit opcode, top payload bit clear
    assign is_lu12i = inst.imm.opcode == id_pkg::OP_LU12I && !inst.imm.payload[15];
    assign is_jirl  = inst.imm.opcode == id_pkg::OP_JIRL;
    assign is_b     = inst.imm.opcode == id_pkg::OP_B;
    assign is_bl    = inst.imm.opcode == id_pkg::OP_BL;
    assign is_beq   = inst.imm.opcode == id_pkg::OP_BEQ;
    assign is_bne   = inst.imm.opcode == id_pkg::OP_BNE;
    assign is_blt   = inst.imm.opcode == id_pkg::OP_BLT;
    assign is_bltu  = inst.imm.opcode == id_pkg::OP_BLTU;

    assign any_alu3r = is_add | is_sub | is_slt | is_sltu | is_and | is_or | is_xor | is_nor;
    assign cond_br   = is_beq | is_bne | is_blt | is_bltu;

    // immediate fields
    assign i12 = inst.imm.payload[11:0];
    assign i16 = inst.imm.payload;
    assign i20 = {inst.imm.payload[14:0], inst.imm.rj};
    assign i26 = {inst.imm.rj, inst.imm.rd, inst.imm.payload};

    assign need_ui12   = is_andi | is_ori;
    assign need_si12   = is_addi | is_ld | is_st;
    assign need_si20   = is_lu12i;
    assign need_offs16 = is_jirl | cond_br;
    assign need_offs26 = is_b | is_bl;

    assign imm = need_ui12   ? {20'h0, i12} :
                 need_si12   ? {{20{i12[11]}}, i12} :
                 need_si20   ? {i20, 12'h0} :
                 need_offs16 ? {{14{i16[15]}}, i16, 2'b00} :
                 need_offs26 ? {{4{i26[25]}}, i26, 2'b00} :
                 32'h0;

    assign alu_op[id_pkg::ALU_ADD]  = is_add | is_addi | is_ld | is_st | is_jirl | is_bl;
    assign alu_op[id_pkg::ALU_SUB]  = is_sub;
    assign alu_op[id_pkg::ALU_SLT]  = is_slt;
    assign alu_op[id_pkg::ALU_SLTU] = is_sltu;
    assign alu_op[id_pkg::ALU_AND]  = is_and | is_andi;
    assign alu_op[id_pkg::ALU_NOR]  = is_nor;
    assign alu_op[id_pkg::ALU_OR]   = is_or | is_ori;
    assign alu_op[id_pkg::ALU_XOR]  = is_xor;
    assign alu_op[id_pkg::ALU_LUI]  = is_lu12i;

    // link value is pc + 4
    assign src1_is_pc  = is_bl | is_jirl;
    assign src2_is_4   = is_bl | is_jirl;
    assign src2_is_imm = is_addi | is_andi | is_ori | is_lu12i | is_ld | is_st;

    assign mem_en       = is_ld | is_st;
    assign mem_we       = is_st;
    assign res_from_mem = is_ld;

    assign dest  = is_bl ? id_pkg::REG_AW'(1) : inst.reg3.rd;
    assign gr_we = ~is_st & ~cond_br & ~is_b & (dest != '0);

    // stores and branches compare or store rd
    assign raddr1 = (is_st | cond_br) ? inst.reg3.rd : inst.reg3.rk;
    assign raddr2 = inst.reg3.rj;
    assign reads1 = any_alu3r | is_st | cond_br;
    assign reads2 = any_alu3r | is_addi | is_andi | is_ori | is_ld | is_st | is_jirl | cond_br;

endmodule

//--- design/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                       clk,
    input  logic [id_pkg::REG_AW-1:0]  raddr1,
    input  logic [id_pkg::REG_AW-1:0]  raddr2,
    input  logic                       we,
    input  logic [id_pkg::REG_AW-1:0]  waddr,
    input  logic [31:0]                wdata,
    output logic [31:0]                rdata1,
    output logic [31:0]                rdata2
);

    logic [31:0] rf [0:id_pkg::REG_NUM-1];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? 32'h0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'h0 : rf[raddr2];

endmodule

//--- design/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass (
    input  logic [id_pkg::REG_AW-1:0]  raddr1,
    input  logic [id_pkg::REG_AW-1:0]  raddr2,
    input  logic                       reads1,
    input  logic                       reads2,
    input  logic [31:0]                rdata1,
    input  logic [31:0]                rdata2,
    input  logic                       es_fwd_valid,
    input  logic                       es_fwd_we,
    input  logic [id_pkg::REG_AW-1:0]  es_fwd_dest,
    input  logic [31:0]                es_fwd_result,
    input  logic                       es_fwd_load,
    input  logic                       ms_fwd_valid,
    input  logic                       ms_fwd_we,
    input  logic [id_pkg::REG_AW-1:0]  ms_fwd_dest,
    input  logic [31:0]                ms_fwd_result,
    input  logic                       ws_fwd_valid,
    input  logic                       ws_fwd_we,
    input  logic [id_pkg::REG_AW-1:0]  ws_fwd_dest,
    input  logic [31:0]                ws_fwd_result,
    output logic [31:0]                src1_value,
    output logic [31:0]                src2_value,
    output logic                       load_use
);

    logic es_hit1, es_hit2, ms_hit1, ms_hit2, ws_hit1, ws_hit2;

    // r0 reads are never bypassed
    function automatic logic fwd_hit(input logic valid,
                                     input logic we,
                                     input logic [id_pkg::REG_AW-1:0] dest,
                                     input logic [id_pkg::REG_AW-1:0] addr,
                                     input logic used);
        return valid && we && used && (addr != '0) && (dest == addr);
    endfunction

    assign es_hit1 = fwd_hit(es_fwd_valid, es_fwd_we, es_fwd_dest, raddr1, reads1);
    assign es_hit2 = fwd_hit(es_fwd_valid, es_fwd_we, es_fwd_dest, raddr2, reads2);
    assign ms_hit1 = fwd_hit(ms_fwd_valid, ms_fwd_we, ms_fwd_dest, raddr1, reads1);
    assign ms_hit2 = fwd_hit(ms_fwd_valid, ms_fwd_we, ms_fwd_dest, raddr2, reads2);
    assign ws_hit1 = fwd_hit(ws_fwd_valid, ws_fwd_we, ws_fwd_dest, raddr1, reads1);
    assign ws_hit2 = fwd_hit(ws_fwd_valid, ws_fwd_we, ws_fwd_dest, raddr2, reads2);

    // youngest producer wins
    assign src1_value = es_hit1 ? es_fwd_result :
                        ms_hit1 ? ms_fwd_result :
                        ws_hit1 ? ws_fwd_result : rdata1;
    assign src2_value = es_hit2 ? es_fwd_result :
                        ms_hit2 ? ms_fwd_result :
                        ws_hit2 ? ws_fwd_result : rdata2;

    // load data not ready until memory stage
    assign load_use = es_fwd_load & (es_hit1 | es_hit2);

endmodule

//--- design/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
    input  logic [31:0] pc,
    input  logic [31:0] imm,
    input  logic [31:0] rj_value,
    input  logic [31:0] rd_value,
    input  logic        is_jirl,
    input  logic        is_b,
    input  logic        is_bl,
    input  logic        is_beq,
    input  logic        is_bne,
    input  logic        is_blt,
    input  logic        is_bltu,
    input  logic        valid,
    output logic        br_taken,
    output logic [31:0] br_target
);

    logic [32:0] diff;
    logic        rj_eq_rd, rj_lt_rd, rj_ltu_rd;

    // borrow out gives the unsigned compare
    assign diff      = {1'b0, rj_value} - {1'b0, rd_value};
    assign rj_eq_rd  = diff[31:0] == 32'h0;
    assign rj_ltu_rd = diff[32];
    // signs differ, so the negative one is smaller
    assign rj_lt_rd  = (rj_value[31] ^ rd_value[31]) ? rj_value[31] : diff[31];

    assign br_taken = valid & (is_jirl | is_b | is_bl
                             | (is_beq  &  rj_eq_rd)
                             | (is_bne  & ~rj_eq_rd)
                             | (is_blt  &  rj_lt_rd)
                             | (is_bltu &  rj_ltu_rd));

    assign br_target = is_jirl ? rj_value + imm : pc + imm;

endmodule

//--- design/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         fs_to_ds_valid,
    input  logic [31:0]                  fs_inst,
    input  logic [31:0]                  fs_pc,
    output logic                         ds_allowin,
    input  logic                         es_allowin,
    output logic                         ds_to_es_valid,
    output logic [31:0]                  es_pc,
    output logic [31:0]                  es_imm,
    output logic [31:0]                  es_src1_value,
    output logic [31:0]                  es_src2_value,
    output logic [id_pkg::ALU_OP_W-1:0]  es_alu_op,
    output logic                         es_src1_is_pc,
    output logic                         es_src2_is_imm,
    output logic                         es_src2_is_4,
    output logic                         es_mem_en,
    output logic                         es_mem_we,
    output logic [id_pkg::REG_AW-1:0]    es_dest,
    output logic                         es_gr_we,
    output logic                         es_res_from_mem,
    input  logic                         es_fwd_valid,
    input  logic                         es_fwd_we,
    input  logic [id_pkg::REG_AW-1:0]    es_fwd_dest,
    input  logic [31:0]                  es_fwd_result,
    input  logic                         es_fwd_load,
    input  logic                         ms_fwd_valid,
    input  logic                         ms_fwd_we,
    input  logic [id_pkg::REG_AW-1:0]    ms_fwd_dest,
    input  logic [31:0]                  ms_fwd_result,
    input  logic                         ws_fwd_valid,
    input  logic                         ws_fwd_we,
    input  logic [id_pkg::REG_AW-1:0]    ws_fwd_dest,
    input  logic [31:0]                  ws_fwd_result,
    input  logic                         wb_we,
    input  logic [id_pkg::REG_AW-1:0]    wb_addr,
    input  logic [31:0]                  wb_data,
    output logic                         br_taken,
    output logic [31:0]                  br_target
);

    id_pkg::inst_t inst_r;
    logic          ds_valid, load_use, reads1, reads2;
    logic          is_jirl, is_b, is_bl, is_beq, is_bne, is_blt, is_bltu;
    logic [id_pkg::REG_AW-1:0] raddr1, raddr2;
    logic [31:0]   rdata1, rdata2;

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            inst_r <= fs_inst;
            es_pc  <= fs_pc;
        end
    end

    ds_control u_ctrl (
        .clk(clk), .reset(reset), .fs_to_ds_valid(fs_to_ds_valid),
        .es_allowin(es_allowin), .load_use(load_use), .ds_valid(ds_valid),
        .ds_allowin(ds_allowin), .ds_to_es_valid(ds_to_es_valid)
    );

    inst_decoder u_dec (
        .inst(inst_r), .alu_op(es_alu_op), .src1_is_pc(es_src1_is_pc),
        .src2_is_imm(es_src2_is_imm), .src2_is_4(es_src2_is_4), .mem_en(es_mem_en),
        .mem_we(es_mem_we), .dest(es_dest), .gr_we(es_gr_we),
        .res_from_mem(es_res_from_mem), .imm(es_imm), .raddr1(raddr1), .raddr2(raddr2),
        .reads1(reads1), .reads2(reads2), .is_jirl(is_jirl), .is_b(is_b), .is_bl(is_bl),
        .is_beq(is_beq), .is_bne(is_bne), .is_blt(is_blt), .is_bltu(is_bltu)
    );

    regfile u_rf (
        .clk(clk), .raddr1(raddr1), .raddr2(raddr2), .we(wb_we), .waddr(wb_addr),
        .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
    );

    operand_bypass u_byp (
        .raddr1(raddr1), .raddr2(raddr2), .reads1(reads1), .reads2(reads2),
        .rdata1(rdata1), .rdata2(rdata2),
        .es_fwd_valid(es_fwd_valid), .es_fwd_we(es_fwd_we), .es_fwd_dest(es_fwd_dest),
        .es_fwd_result(es_fwd_result), .es_fwd_load(es_fwd_load),
        .ms_fwd_valid(ms_fwd_valid), .ms_fwd_we(ms_fwd_we), .ms_fwd_dest(ms_fwd_dest),
        .ms_fwd_result(ms_fwd_result),
        .ws_fwd_valid(ws_fwd_valid), .ws_fwd_we(ws_fwd_we), .ws_fwd_dest(ws_fwd_dest),
        .ws_fwd_result(ws_fwd_result),
        .src1_value(es_src1_value), .src2_value(es_src2_value), .load_use(load_use)
    );

    // rj comes in on port 2, rd on port 1
    branch_unit u_br (
        .pc(es_pc), .imm(es_imm), .rj_value(es_src2_value), .rd_value(es_src1_value),
        .is_jirl(is_jirl), .is_b(is_b), .is_bl(is_bl), .is_beq(is_beq), .is_bne(is_bne),
        .is_blt(is_blt), .is_bltu(is_bltu), .valid(ds_to_es_valid),
        .br_taken(br_taken), .br_target(br_target)
    );

    // decoded fields hold until the instruction leaves
    a_stall_hold: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid && !(ds_to_es_valid && es_allowin)
            |=> $stable({es_pc, es_imm, es_alu_op, es_dest, es_gr_we})
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    always #4 clk = ~clk;

endmodule

//--- sim/tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage;

    logic clk, reset, fs_to_ds_valid, es_allowin, ds_allowin, ds_to_es_valid;
    logic [31:0] fs_inst, fs_pc, es_pc, es_imm, es_src1_value, es_src2_value, br_target;
    logic [8:0]  es_alu_op;
    logic        es_src1_is_pc, es_src2_is_imm, es_src2_is_4, es_mem_en, es_mem_we;
    logic        es_gr_we, es_res_from_mem, br_taken, wb_we, es_fwd_load;
    logic        es_fwd_valid, es_fwd_we, ms_fwd_valid, ms_fwd_we, ws_fwd_valid, ws_fwd_we;
    logic [4:0]  es_dest, es_fwd_dest, ms_fwd_dest, ws_fwd_dest, wb_addr;
    logic [31:0] es_fwd_result, ms_fwd_result, ws_fwd_result, wb_data;

    logic [31:0] lfsr = 32'd93811;
    logic [31:0] shadow [0:31];
    int          n_inst = 300;
    int          errors = 0;
    int          accepted = 0;
    logic        tb_valid;
    int          cur_kind;
    // kind of the instruction offered on the fetch port
    int          fs_kind;
    logic [31:0] cur_word, cur_pc;

    // reference decode outputs
    logic [8:0]  e_alu;
    logic [31:0] e_imm, e_src1, e_src2, e_target;
    logic [4:0]  e_dest, e_raddr1, e_raddr2;
    logic [5:0]  e_ctrl;
    logic        e_gr_we, e_reads1, e_reads2, e_lu, e_allowin, e_valid, e_taken;
    logic        e_cond, e_eq, e_lt, e_ltu;

    tb_clock u_clk (.clk(clk), .reset(reset));

    id_stage dut (.*);

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic make_inst(input int kind, output logic [31:0] word);
        id_pkg::inst_t u;
        logic [31:0] r;
        logic [4:0]  rk, rj, rd, fn;
        logic [15:0] p;
        r = take_bits(3);
        rk = {2'b0, r[2:0]};
        r = take_bits(3);
        rj = {2'b0, r[2:0]};
        r = take_bits(3);
        rd = {2'b0, r[2:0]};
        r = take_bits(16);
        p = r[15:0];
        case (kind)
            0: fn = id_pkg::FUNC_ADD;
            1: fn = id_pkg::FUNC_SUB;
            2: fn = id_pkg::FUNC_SLT;
            3: fn = id_pkg::FUNC_SLTU;
            4: fn = id_pkg::FUNC_AND;
            5: fn = id_pkg::FUNC_OR;
            6: fn = id_pkg::FUNC_XOR;
            default: fn = id_pkg::FUNC_NOR;
        endcase
        u.reg3 = '{id_pkg::OP_ARITH, id_pkg::OP_ALU3R, id_pkg::OP_LO_ALU3R, fn, rk, rj, rd};
        case (kind)
            8:  u.imm = '{id_pkg::OP_ARITH, {id_pkg::OP_ADDI, p[11:0]}, rj, rd};
            9:  u.imm = '{id_pkg::OP_ARITH, {id_pkg::OP_ANDI, p[11:0]}, rj, rd};
            10: u.imm = '{id_pkg::OP_ARITH, {id_pkg::OP_ORI, p[11:0]}, rj, rd};
            11: u.imm = '{id_pkg::OP_LU12I, {1'b0, p[14:0]}, rj, rd};
            12: u.imm = '{id_pkg::OP_MEM, {id_pkg::OP_LD_W, p[11:0]}, rj, rd};
            13: u.imm = '{id_pkg::OP_MEM, {id_pkg::OP_ST_W, p[11:0]}, rj, rd};
            14: u.imm = '{id_pkg::OP_BEQ, p, rj, rd};
            15: u.imm = '{id_pkg::OP_BNE, p, rj, rd};
            16: u.imm = '{id_pkg::OP_BLT, p, rj, rd};
            17: u.imm = '{id_pkg::OP_BLTU, p, rj, rd};
            18: u.imm = '{id_pkg::OP_B, p, rj, rd};
            19: u.imm = '{id_pkg::OP_BL, p, rj, rd};
            20: u.imm = '{id_pkg::OP_JIRL, p, rj, rd};
            default: ;
        endcase
        word = u;
    endtask

    function automatic logic [31:0] ref_src(input logic [4:0] a);
        if (a == 5'd0) return 32'h0;
        if (es_fwd_valid && es_fwd_we && es_fwd_dest == a) return es_fwd_result;
        if (ms_fwd_valid && ms_fwd_we && ms_fwd_dest == a) return ms_fwd_result;
        if (ws_fwd_valid && ws_fwd_we && ws_fwd_dest == a) return ws_fwd_result;
        return shadow[a];
    endfunction

    task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, sig, got, exp);
    endtask

    // kinds: 0-7 alu3r, 8 addi, 9 andi, 10 ori, 11 lu12i, 12 ld, 13 st,
    // 14-17 beq bne blt bltu, 18 b, 19 bl, 20 jirl
    always_comb begin
        e_alu = '0;
        case (cur_kind)
            0, 8, 12, 13, 19, 20: e_alu[id_pkg::ALU_ADD] = 1'b1;
            1: e_alu[id_pkg::ALU_SUB] = 1'b1;
            2: e_alu[id_pkg::ALU_SLT] = 1'b1;
            3: e_alu[id_pkg::ALU_SLTU] = 1'b1;
            4, 9: e_alu[id_pkg::ALU_AND] = 1'b1;
            5, 10: e_alu[id_pkg::ALU_OR] = 1'b1;
            6: e_alu[id_pkg::ALU_XOR] = 1'b1;
            7: e_alu[id_pkg::ALU_NOR] = 1'b1;
            11: e_alu[id_pkg::ALU_LUI] = 1'b1;
            default: ;
        endcase
        case (cur_kind)
            8, 12, 13: e_imm = {{20{cur_word[21]}}, cur_word[21:10]};
            9, 10: e_imm = {20'h0, cur_word[21:10]};
            11: e_imm = {cur_word[24:5], 12'h0};
            14, 15, 16, 17, 20: e_imm = {{14{cur_word[25]}}, cur_word[25:10], 2'b00};
            18, 19: e_imm = {{4{cur_word[9]}}, cur_word[9:0], cur_word[25:10], 2'b00};
            default: e_imm = 32'h0;
        endcase
        e_cond   = cur_kind >= 14 && cur_kind <= 17;
        e_dest   = (cur_kind == 19) ? 5'd1 : cur_word[4:0];
        e_gr_we  = cur_kind != 13 && !e_cond && cur_kind != 18 && e_dest != 5'd0;
        e_ctrl   = {cur_kind == 19 || cur_kind == 20, cur_kind >= 8 && cur_kind <= 13,
                    cur_kind == 19 || cur_kind == 20, cur_kind == 12 || cur_kind == 13,
                    cur_kind == 13, cur_kind == 12};
        e_raddr1 = (cur_kind == 13 || e_cond) ? cur_word[4:0] : cur_word[14:10];
        e_raddr2 = cur_word[9:5];
        e_reads1 = cur_kind <= 7 || cur_kind == 13 || e_cond;
        e_reads2 = cur_kind <= 10 || cur_kind == 12 || cur_kind == 13 || e_cond
                   || cur_kind == 20;
        e_src1   = ref_src(e_raddr1);
        e_src2   = ref_src(e_raddr2);
        e_lu     = tb_valid && es_fwd_valid && es_fwd_we && es_fwd_load && es_fwd_dest != 0
                   && ((e_reads1 && es_fwd_dest == e_raddr1)
                       || (e_reads2 && es_fwd_dest == e_raddr2));
        e_valid   = tb_valid && !e_lu;
        e_allowin = !tb_valid || (!e_lu && es_allowin);
        // rj is source 2, rd is source 1
        e_eq  = e_src2 == e_src1;
        e_lt  = $signed(e_src2) < $signed(e_src1);
        e_ltu = e_src2 < e_src1;
        e_taken = e_valid && (cur_kind >= 18 || (cur_kind == 14 && e_eq)
                  || (cur_kind == 15 && !e_eq) || (cur_kind == 16 && e_lt)
                  || (cur_kind == 17 && e_ltu));
        e_target = (cur_kind == 20) ? e_src2 + e_imm : cur_pc + e_imm;
    end

    always_ff @(posedge clk) begin
        if (wb_we && wb_addr != 5'd0) shadow[wb_addr] <= wb_data;
        if (reset) begin
            tb_valid <= 1'b0;
            cur_kind <= 0;
        end else if (e_allowin) begin
            tb_valid <= fs_to_ds_valid;
            if (fs_to_ds_valid) begin
                cur_word <= fs_inst;
                cur_pc   <= fs_pc;
                cur_kind <= fs_kind;
                accepted <= accepted + 1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) $fell(reset)
        |-> !ds_to_es_valid && !br_taken && ds_allowin)
        else begin
            errors++;
            $display("reset state wrong at t=%0t: outputs not idle", $time);
        end
    a_allowin: assert property (@(posedge clk) disable iff (reset) ds_allowin == e_allowin)
        else mismatch("ds_allowin", $sampled(ds_allowin), $sampled(e_allowin));
    a_valid: assert property (@(posedge clk) disable iff (reset) ds_to_es_valid == e_valid)
        else mismatch("ds_to_es_valid", $sampled(ds_to_es_valid), $sampled(e_valid));
    a_alu: assert property (@(posedge clk) disable iff (reset) tb_valid |-> es_alu_op == e_alu)
        else mismatch("es_alu_op", $sampled(es_alu_op), $sampled(e_alu));
    a_imm: assert property (@(posedge clk) disable iff (reset) tb_valid |-> es_imm == e_imm)
        else mismatch("es_imm", $sampled(es_imm), $sampled(e_imm));
    a_pc: assert property (@(posedge clk) disable iff (reset) tb_valid |-> es_pc == cur_pc)
        else mismatch("es_pc", $sampled(es_pc), $sampled(cur_pc));
    a_dest: assert property (@(posedge clk) disable iff (reset)
        tb_valid |-> es_dest == e_dest && es_gr_we == e_gr_we)
        else mismatch("es_dest/es_gr_we", $sampled({es_dest, es_gr_we}),
                      $sampled({e_dest, e_gr_we}));
    a_ctrl: assert property (@(posedge clk) disable iff (reset) tb_valid
        |-> {es_src1_is_pc, es_src2_is_imm, es_src2_is_4, es_mem_en, es_mem_we,
             es_res_from_mem} == e_ctrl)
        else mismatch("es control bits", $sampled({es_src1_is_pc, es_src2_is_imm,
                      es_src2_is_4, es_mem_en, es_mem_we, es_res_from_mem}), $sampled(e_ctrl));
    a_src1: assert property (@(posedge clk) disable iff (reset)
        tb_valid && e_reads1 |-> es_src1_value == e_src1)
        else mismatch("es_src1_value", $sampled(es_src1_value), $sampled(e_src1));
    a_src2: assert property (@(posedge clk) disable iff (reset)
        tb_valid && e_reads2 |-> es_src2_value == e_src2)
        else mismatch("es_src2_value", $sampled(es_src2_value), $sampled(e_src2));
    a_taken: assert property (@(posedge clk) disable iff (reset) br_taken == e_taken)
        else mismatch("br_taken", $sampled(br_taken), $sampled(e_taken));
    a_target: assert property (@(posedge clk) disable iff (reset)
        e_taken |-> br_target == e_target)
        else mismatch("br_target", $sampled(br_target), $sampled(e_target));
    a_taken_gated: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> ds_to_es_valid)
        else begin
            errors++;
            $display("branch taken at t=%0t while no valid instruction left decode", $time);
        end
    a_backpressure: assert property (@(posedge clk) disable iff (reset)
        tb_valid && !es_allowin |=> $stable({es_pc, es_imm, es_alu_op, es_dest,
            es_src1_is_pc, es_src2_is_imm, es_src2_is_4, es_mem_en, es_mem_we,
            es_gr_we, es_res_from_mem}))
        else begin
            errors++;
            $display("es outputs changed at t=%0t while execute was not accepting", $time);
        end

    initial begin
        logic [31:0] r;
        int          last, kind;
        {fs_to_ds_valid, es_allowin, es_fwd_valid, es_fwd_we, es_fwd_load} = '0;
        {ms_fwd_valid, ms_fwd_we, ws_fwd_valid, ws_fwd_we, wb_we} = '0;
        {es_fwd_dest, ms_fwd_dest, ws_fwd_dest, wb_addr} = '0;
        {fs_inst, fs_pc, es_fwd_result, ms_fwd_result, ws_fwd_result, wb_data} = '0;
        fs_kind = 0;
        @(negedge reset);
        // fill the register file through writeback
        for (int a = 1; a < 32; a++) begin
            @(negedge clk);
            r = take_bits(32);
            wb_we   = 1'b1;
            wb_addr = a[4:0];
            wb_data = r ^ {a[7:0], a[7:0], a[7:0], a[7:0]};
        end
        last = -1;
        while (accepted < n_inst) begin
            @(negedge clk);
            if (accepted != last) begin
                r = take_bits(5);
                kind = r % 21;
                make_inst(kind, fs_inst);
                r = take_bits(30);
                fs_pc   = {r[29:0], 2'b00};
                fs_kind = kind;
                last    = accepted;
            end
            r = take_bits(2);
            fs_to_ds_valid = |r[1:0];
            r = take_bits(2);
            es_allowin = |r[1:0];
            r = take_bits(7);
            {es_fwd_valid, es_fwd_we, es_fwd_dest} = {r[6:5], 2'b0, r[2:0]};
            es_fwd_load = r[6] & r[5] & r[4];
            es_fwd_result = take_bits(32);
            r = take_bits(5);
            {ms_fwd_valid, ms_fwd_we, ms_fwd_dest} = {r[4:3], 2'b0, r[2:0]};
            ms_fwd_result = take_bits(32);
            r = take_bits(5);
            {ws_fwd_valid, ws_fwd_we, ws_fwd_dest} = {r[4:3], 2'b0, r[2:0]};
            ws_fwd_result = take_bits(32);
            r = take_bits(4);
            {wb_we, wb_addr} = {r[3], 2'b0, r[2:0]};
            wb_data = take_bits(32);
        end
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        repeat (4) @(negedge clk);
        $display("errors: %0d, instructions accepted: %0d", errors, accepted);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((n_inst * 8 + 64) * 8);
        $display("watchdog expired after %0d of %0d instructions", accepted, n_inst);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- id_stage.f
design/id_pkg.sv
design/ds_control.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
sim/tb_clock.sv
sim/tb_id_stage.sv
